//--- source/gcn_consts.svh
// widths and sizes for the aggregation stage, included by the package and array-sizing RTL
`ifndef GCN_CONSTS_SVH
`define GCN_CONSTS_SVH

// number of edge processing elements
`define NUM_EDGE_PE 4

// node id width, also the table address width
`define NODE_ID_W 8

// neighbor count field of a neighbor-info word
`define NEIGH_CNT_W 4

// feature value and running sum width
`define FEAT_W 16

// pe tag width, log2 of the pe count
`define TAG_W 2

// entries in each memory table
`define MEM_DEPTH 256

`endif

//--- source/gcn_pkg.sv
// shared types of the aggregation stage, imported by every module that uses them
`include "gcn_consts.svh"

package gcn_pkg;

    typedef logic [`NODE_ID_W-1:0] node_id_t;

    // index of a pe, also the response tag
    typedef logic [`TAG_W-1:0] pe_tag_t;

    // feature value or neighbor sum
    typedef logic [`FEAT_W-1:0] feat_t;

    // bus request kinds, picks the memory channel
    typedef enum logic {
        REQ_NEIGHBOR = 1'b0,
        REQ_FEATURE  = 1'b1
    } req_type_t;

    // neighbors sit at consecutive ids base .. base + count - 1
    typedef struct packed {
        logic [`FEAT_W-`NEIGH_CNT_W-`NODE_ID_W-1:0] pad;
        logic [`NEIGH_CNT_W-1:0]                    count;
        node_id_t                                   base;
    } neigh_info_t;

    // one memory word, read as neighbor info or as a feature
    typedef union packed {
        neigh_info_t neigh;
        feat_t       feat;
    } mem_word_u;

endpackage

//--- source/rr_arbiter.sv
// round-robin arbiter, one-hot grant among request levels, used for the bus and the collector
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int num_reqs = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);

    // pointer needs at least one bit even for a single requester
    localparam int ptr_w = (num_reqs > 1) ? $clog2(num_reqs) : 1;

    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] next_ptr;

    // search starts at the pointer and wraps around
    always_comb begin
        int   idx;
        logic found;
        grants   = '0;
        next_ptr = ptr;
        found    = 1'b0;
        for (int k = 0; k < num_reqs; k++) begin
            idx = (int'(ptr) + k) % num_reqs;
            if (!found && reqs[idx]) begin
                found       = 1'b1;
                grants[idx] = 1'b1;
                // winner moves to lowest priority
                next_ptr    = ptr_w'((idx + 1) % num_reqs);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else begin
            ptr <= next_ptr;
        end
    end

    a_grants_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grants));

endmodule

//--- source/node_dispatcher.sv
// node dispatcher, accepts streamed node ids and starts the lowest-index idle pe
`timescale 1ns/1ps
`include "gcn_consts.svh"

module node_dispatcher import gcn_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    node_valid,
    input  node_id_t                node_id,
    output logic                    node_ready,
    input  logic [`NUM_EDGE_PE-1:0] pe_busy,
    output logic [`NUM_EDGE_PE-1:0] pe_start,
    output node_id_t                pe_node
);

    logic [`NUM_EDGE_PE-1:0] avail;
    logic [`NUM_EDGE_PE-1:0] pick;
    logic                    accept;

    // a pe started this cycle still reads not busy, so the start pulse reserves it
    assign avail      = ~pe_busy & ~pe_start;
    assign node_ready = |avail;

    // strobes while not ready are dropped
    assign accept = node_valid && node_ready;

    // lowest index idle pe wins
    always_comb begin
        logic found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (!found && avail[i]) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    // start pulse lands one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            pe_start <= '0;
        end else begin
            pe_start <= accept ? pick : '0;
        end
    end

    // node id shared by all pes, only the started one latches it
    always_ff @(posedge clk) begin
        if (accept) begin
            pe_node <= node_id;
        end
    end

    a_no_strobe_when_full: assert property (
        @(posedge clk) disable iff (reset) node_valid |-> node_ready
    );

endmodule

//--- source/edge_pe.sv
// edge pe, fetches a node's neighbor info then each neighbor feature and sums them
`timescale 1ns/1ps
`include "gcn_consts.svh"

module edge_pe import gcn_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  pe_tag_t   pe_index,
    input  logic      start,
    input  node_id_t  start_node,
    output logic      busy,
    output logic      req,
    output req_type_t req_type,
    output node_id_t  req_node,
    input  logic      grant,
    input  logic      resp_valid,
    input  pe_tag_t   resp_tag,
    input  mem_word_u resp_word,
    output logic      done,
    output node_id_t  res_node,
    output feat_t     res_sum,
    input  logic      taken
);

    typedef enum logic [2:0] {
        s_idle,
        s_nb_req,
        s_nb_wait,
        s_fv_req,
        s_fv_wait,
        s_done
    } pe_state_t;

    pe_state_t               state;
    node_id_t                node_q;
    node_id_t                addr_q;
    logic [`NEIGH_CNT_W-1:0] remain_q;
    feat_t                   sum_q;
    logic                    resp_hit;

    // response bus is broadcast, tag picks the owner
    assign resp_hit = resp_valid && (resp_tag == pe_index);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_nb_req;
                    end
                end
                // request level held until the grant pulse
                s_nb_req: begin
                    if (grant) begin
                        state <= s_nb_wait;
                    end
                end
                s_nb_wait: begin
                    if (resp_hit) begin
                        // isolated node, nothing to fetch
                        state <= (resp_word.neigh.count == '0) ? s_done : s_fv_req;
                    end
                end
                s_fv_req: begin
                    if (grant) begin
                        state <= s_fv_wait;
                    end
                end
                s_fv_wait: begin
                    if (resp_hit) begin
                        state <= (remain_q == 'd1) ? s_done : s_fv_req;
                    end
                end
                s_done: begin
                    if (taken) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // datapath, the fsm decides which fields are live
    always_ff @(posedge clk) begin
        case (state)
            s_idle: begin
                if (start) begin
                    node_q <= start_node;
                    sum_q  <= '0;
                end
            end
            s_nb_wait: begin
                if (resp_hit) begin
                    addr_q   <= resp_word.neigh.base;
                    remain_q <= resp_word.neigh.count;
                end
            end
            s_fv_wait: begin
                if (resp_hit) begin
                    // wraps at feat width
                    sum_q    <= sum_q + resp_word.feat;
                    addr_q   <= addr_q + 1'b1;
                    remain_q <= remain_q - 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign busy     = (state != s_idle);
    assign req      = (state == s_nb_req) || (state == s_fv_req);
    assign req_type = (state == s_fv_req) ? REQ_FEATURE : REQ_NEIGHBOR;
    // neighbor request asks for the node itself, feature request for the current neighbor
    assign req_node = (state == s_fv_req) ? addr_q : node_q;
    assign done     = (state == s_done);
    assign res_node = node_q;
    assign res_sum  = sum_q;

    // memory answers only to an outstanding request
    a_resp_when_waiting: assert property (
        @(posedge clk) disable iff (reset)
        resp_hit |-> (state == s_nb_wait || state == s_fv_wait)
    );

endmodule

//--- source/bus_arbiter.sv
// shared bus arbiter, grants one pe request per cycle and routes it to the memory channel
`timescale 1ns/1ps
`include "gcn_consts.svh"

module bus_arbiter import gcn_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic      [`NUM_EDGE_PE-1:0] req,
    input  req_type_t [`NUM_EDGE_PE-1:0] req_type,
    input  node_id_t  [`NUM_EDGE_PE-1:0] req_node,
    output logic      [`NUM_EDGE_PE-1:0] grant,
    output logic                         nb_valid,
    output node_id_t                     nb_node,
    output pe_tag_t                      nb_tag,
    output logic                         fv_valid,
    output node_id_t                     fv_node,
    output pe_tag_t                      fv_tag
);

    logic      any_grant;
    pe_tag_t   win_idx;
    logic      gnt_valid_q;
    req_type_t gnt_type_q;
    node_id_t  gnt_node_q;
    pe_tag_t   gnt_tag_q;

    rr_arbiter #(
        .num_reqs(`NUM_EDGE_PE)
    ) u_rr_arbiter (
        .clk   (clk),
        .reset (reset),
        .reqs  (req),
        .grants(grant)
    );

    // one-hot grant to winner index
    always_comb begin
        win_idx = '0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (grant[i]) begin
                win_idx = pe_tag_t'(i);
            end
        end
    end

    assign any_grant = |grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            gnt_valid_q <= 1'b0;
        end else begin
            gnt_valid_q <= any_grant;
        end
    end

    // winner's request, issued one cycle after its grant
    always_ff @(posedge clk) begin
        gnt_type_q <= req_type[win_idx];
        gnt_node_q <= req_node[win_idx];
        gnt_tag_q  <= win_idx;
    end

    // type steers the single registered request onto one channel
    assign nb_valid = gnt_valid_q && (gnt_type_q == REQ_NEIGHBOR);
    assign fv_valid = gnt_valid_q && (gnt_type_q == REQ_FEATURE);
    assign nb_node  = gnt_node_q;
    assign fv_node  = gnt_node_q;
    assign nb_tag   = gnt_tag_q;
    assign fv_tag   = gnt_tag_q;

    a_one_channel: assert property (
        @(posedge clk) disable iff (reset) !(nb_valid && fv_valid)
    );

endmodule

//--- source/graph_mem_cntl.sv
// graph memory controller, neighbor and feature tables with a load port and tagged responses
`timescale 1ns/1ps
`include "gcn_consts.svh"

module graph_mem_cntl import gcn_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_wr_en,
    input  logic      mem_wr_sel,
    input  node_id_t  mem_wr_addr,
    input  mem_word_u mem_wr_data,
    input  logic      nb_valid,
    input  node_id_t  nb_node,
    input  pe_tag_t   nb_tag,
    input  logic      fv_valid,
    input  node_id_t  fv_node,
    input  pe_tag_t   fv_tag,
    output logic      resp_valid,
    output pe_tag_t   resp_tag,
    output mem_word_u resp_word
);

    // neighbor info per node id
    mem_word_u neigh_tab [`MEM_DEPTH];
    // feature value per node id
    mem_word_u feat_tab  [`MEM_DEPTH];

    // load port, sel 0 writes neighbor info, 1 writes a feature
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            if (mem_wr_sel) begin
                feat_tab[mem_wr_addr] <= mem_wr_data;
            end else begin
                neigh_tab[mem_wr_addr] <= mem_wr_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= nb_valid || fv_valid;
        end
    end

    // single read port, the bus never drives both channels at once
    always_ff @(posedge clk) begin
        if (nb_valid) begin
            resp_word <= neigh_tab[nb_node];
            resp_tag  <= nb_tag;
        end else if (fv_valid) begin
            resp_word <= feat_tab[fv_node];
            resp_tag  <= fv_tag;
        end
    end

endmodule

//--- source/result_collector.sv
// result collector, drains one finished pe per cycle onto the output strobe
`timescale 1ns/1ps
`include "gcn_consts.svh"

module result_collector import gcn_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic     [`NUM_EDGE_PE-1:0] done,
    input  node_id_t [`NUM_EDGE_PE-1:0] res_node,
    input  feat_t    [`NUM_EDGE_PE-1:0] res_sum,
    output logic     [`NUM_EDGE_PE-1:0] taken,
    output logic                        result_valid,
    output node_id_t                    result_node,
    output feat_t                       result_sum
);

    pe_tag_t win_idx;

    // grant doubles as taken, done drops the next cycle so it stays a pulse
    rr_arbiter #(
        .num_reqs(`NUM_EDGE_PE)
    ) u_rr_arbiter (
        .clk   (clk),
        .reset (reset),
        .reqs  (done),
        .grants(taken)
    );

    always_comb begin
        win_idx = '0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (taken[i]) begin
                win_idx = pe_tag_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= |taken;
        end
    end

    always_ff @(posedge clk) begin
        result_node <= res_node[win_idx];
        result_sum  <= res_sum[win_idx];
    end

endmodule

//--- source/gcn_aggregate_top.sv
// top of the neighbor-aggregation stage, node stream in, per-node neighbor sums out
`timescale 1ns/1ps
`include "gcn_consts.svh"

module gcn_aggregate_top import gcn_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      node_valid,
    input  node_id_t  node_id,
    output logic      node_ready,
    input  logic      mem_wr_en,
    input  logic      mem_wr_sel,
    input  node_id_t  mem_wr_addr,
    input  mem_word_u mem_wr_data,
    output logic      result_valid,
    output node_id_t  result_node,
    output feat_t     result_sum
);

    // dispatcher to pes
    logic      [`NUM_EDGE_PE-1:0] pe_busy;
    logic      [`NUM_EDGE_PE-1:0] pe_start;
    node_id_t                     pe_node;

    // pes to bus
    logic      [`NUM_EDGE_PE-1:0] req;
    req_type_t [`NUM_EDGE_PE-1:0] req_type;
    node_id_t  [`NUM_EDGE_PE-1:0] req_node;
    logic      [`NUM_EDGE_PE-1:0] grant;

    // bus to memory
    logic      nb_valid;
    node_id_t  nb_node;
    pe_tag_t   nb_tag;
    logic      fv_valid;
    node_id_t  fv_node;
    pe_tag_t   fv_tag;

    // memory response broadcast
    logic      resp_valid;
    pe_tag_t   resp_tag;
    mem_word_u resp_word;

    // pes to collector
    logic      [`NUM_EDGE_PE-1:0] done;
    node_id_t  [`NUM_EDGE_PE-1:0] res_node;
    feat_t     [`NUM_EDGE_PE-1:0] res_sum;
    logic      [`NUM_EDGE_PE-1:0] taken;

    node_dispatcher u_node_dispatcher (
        .clk       (clk),
        .reset     (reset),
        .node_valid(node_valid),
        .node_id   (node_id),
        .node_ready(node_ready),
        .pe_busy   (pe_busy),
        .pe_start  (pe_start),
        .pe_node   (pe_node)
    );

    for (genvar i = 0; i < `NUM_EDGE_PE; i++) begin : pe_gen
        // index doubles as the response tag
        edge_pe u_edge_pe (
            .clk       (clk),
            .reset     (reset),
            .pe_index  (pe_tag_t'(i)),
            .start     (pe_start[i]),
            .start_node(pe_node),
            .busy      (pe_busy[i]),
            .req       (req[i]),
            .req_type  (req_type[i]),
            .req_node  (req_node[i]),
            .grant     (grant[i]),
            .resp_valid(resp_valid),
            .resp_tag  (resp_tag),
            .resp_word (resp_word),
            .done      (done[i]),
            .res_node  (res_node[i]),
            .res_sum   (res_sum[i]),
            .taken     (taken[i])
        );
    end

    bus_arbiter u_bus_arbiter (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .req_type(req_type),
        .req_node(req_node),
        .grant   (grant),
        .nb_valid(nb_valid),
        .nb_node (nb_node),
        .nb_tag  (nb_tag),
        .fv_valid(fv_valid),
        .fv_node (fv_node),
        .fv_tag  (fv_tag)
    );

    graph_mem_cntl u_graph_mem_cntl (
        .clk        (clk),
        .reset      (reset),
        .mem_wr_en  (mem_wr_en),
        .mem_wr_sel (mem_wr_sel),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data),
        .nb_valid   (nb_valid),
        .nb_node    (nb_node),
        .nb_tag     (nb_tag),
        .fv_valid   (fv_valid),
        .fv_node    (fv_node),
        .fv_tag     (fv_tag),
        .resp_valid (resp_valid),
        .resp_tag   (resp_tag),
        .resp_word  (resp_word)
    );

    result_collector u_result_collector (
        .clk         (clk),
        .reset       (reset),
        .done        (done),
        .res_node    (res_node),
        .res_sum     (res_sum),
        .taken       (taken),
        .result_valid(result_valid),
        .result_node (result_node),
        .result_sum  (result_sum)
    );

endmodule

//--- tests/gcn_aggregate_tb.sv
// testbench for the aggregation top, replays the trace file and checks every node result
`timescale 1ns/1ps
`include "gcn_consts.svh"

module gcn_aggregate_tb import gcn_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      node_valid;
    node_id_t  node_id;
    logic      node_ready;
    logic      mem_wr_en;
    logic      mem_wr_sel;
    node_id_t  mem_wr_addr;
    mem_word_u mem_wr_data;
    logic      result_valid;
    node_id_t  result_node;
    feat_t     result_sum;

    // trace contents, table loads and node groups
    logic      wr_sel_q    [$];
    node_id_t  wr_addr_q   [$];
    mem_word_u wr_data_q   [$];
    node_id_t  node_q      [$];
    string     group_name  [$];
    int        group_first [$];
    int        group_len   [$];
    feat_t     exp_sum     [node_id_t];

    // results seen on the output, drained by the running test
    node_id_t  got_node [$];
    feat_t     got_sum  [$];
    bit        pending  [node_id_t];

    integer seed = 32'h7214;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    bit     saw_not_ready;

    gcn_aggregate_top dut (
        .clk         (clk),
        .reset       (reset),
        .node_valid  (node_valid),
        .node_id     (node_id),
        .node_ready  (node_ready),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_sel  (mem_wr_sel),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .result_valid(result_valid),
        .result_node (result_node),
        .result_sum  (result_sum)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // outputs sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            got_node.push_back(result_node);
            got_sum.push_back(result_sum);
        end
        if (!reset && !node_ready) begin
            saw_not_ready = 1'b1;
        end
    end

    // run limit comes from the trace, see read_trace
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            foreach (pending[id]) begin
                $display("node %h gave no result before the timeout", id);
            end
            $display("tests passed %0d failed %0d", tests_passed, tests_failed + 1);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic check_node(input node_id_t expected, input node_id_t actual,
                              input string name);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_sum(input feat_t expected, input feat_t actual, input string name);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_level(input logic expected, input logic actual, input string name);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %b got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_trace(output bit ok);
        integer    fd;
        string     line;
        string     name;
        int        sel;
        int        addr;
        int        data;
        int        max_count;
        mem_word_u word;
        fd = $fopen("tests/aggregate_trace.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            ok        = 1'b1;
            max_count = 0;
            while ($fgets(line, fd)) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                case (line[0])
                    "W": begin
                        void'($sscanf(line, "W %d %h %h", sel, addr, data));
                        word = data[`FEAT_W-1:0];
                        wr_sel_q.push_back(sel[0]);
                        wr_addr_q.push_back(node_id_t'(addr));
                        wr_data_q.push_back(word);
                        // longest neighbor list sets the timeout
                        if (sel == 0 && int'(word.neigh.count) > max_count) begin
                            max_count = word.neigh.count;
                        end
                    end
                    "T": begin
                        void'($sscanf(line, "T %s", name));
                        group_name.push_back(name);
                        group_first.push_back(node_q.size());
                        group_len.push_back(0);
                    end
                    "N": begin
                        void'($sscanf(line, "N %h", addr));
                        node_q.push_back(node_id_t'(addr));
                        group_len[group_len.size()-1] += 1;
                    end
                    "E": begin
                        void'($sscanf(line, "E %h %h", addr, data));
                        exp_sum[node_id_t'(addr)] = feat_t'(data);
                    end
                    default: begin
                        $display("unknown trace line: %s", line);
                    end
                endcase
            end
            $fclose(fd);
            cycle_limit = node_q.size() * (2 + 3 * (max_count + 1) * `NUM_EDGE_PE) + 200;
        end
    endtask

    task automatic load_tables();
        for (int i = 0; i < wr_addr_q.size(); i++) begin
            mem_wr_en   = 1'b1;
            mem_wr_sel  = wr_sel_q[i];
            mem_wr_addr = wr_addr_q[i];
            mem_wr_data = wr_data_q[i];
            @(negedge clk);
        end
        mem_wr_en = 1'b0;
    endtask

    task automatic send_node(input node_id_t id);
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) @(negedge clk);
        // stall here while every pe is busy
        while (!node_ready) begin
            @(negedge clk);
        end
        node_valid = 1'b1;
        node_id    = id;
        @(negedge clk);
        node_valid = 1'b0;
    endtask

    task automatic take_result(input bit single, input node_id_t expect_node);
        node_id_t node;
        feat_t    sum;
        node = got_node.pop_front();
        sum  = got_sum.pop_front();
        if (single) begin
            check_node(expect_node, node, "result_node");
        end
        if (pending.exists(node)) begin
            check_sum(exp_sum[node], sum, "result_sum");
            pending.delete(node);
        end else begin
            $display("result for node %h at %0t ns was not expected", node, $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    task automatic run_group(input int g);
        int       errors_before;
        bit       single;
        node_id_t id;
        errors_before = errors;
        single        = (group_len[g] == 1);
        saw_not_ready = 1'b0;
        for (int i = 0; i < group_len[g]; i++) begin
            id = node_q[group_first[g] + i];
            if (exp_sum.exists(id)) begin
                pending[id] = 1'b1;
            end else begin
                $display("node %h has no expected sum in the trace", id);
                errors++;
            end
        end
        for (int i = 0; i < group_len[g]; i++) begin
            send_node(node_q[group_first[g] + i]);
        end
        // results come back in any order
        while (pending.num() > 0) begin
            @(negedge clk);
            while (got_node.size() > 0) begin
                take_result(single, node_q[group_first[g]]);
            end
        end
        // quiet window catches a second result for the same node
        repeat (8) @(negedge clk);
        while (got_node.size() > 0) begin
            take_result(single, node_q[group_first[g]]);
        end
        if (group_len[g] > `NUM_EDGE_PE && !saw_not_ready) begin
            $display("node_ready never went low although more nodes than pes were sent");
            errors++;
        end
        report_test(group_name[g], errors - errors_before);
    endtask

    initial begin
        bit trace_ok;
        reset       = 1'b1;
        node_valid  = 1'b0;
        node_id     = '0;
        mem_wr_en   = 1'b0;
        mem_wr_sel  = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        read_trace(trace_ok);
        if (!trace_ok) begin
            $display("could not open the trace file tests/aggregate_trace.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            repeat (8) @(negedge clk);
            reset = 1'b0;
            @(negedge clk);
            // idle state before any stimulus
            check_level(1'b0, result_valid, "result_valid");
            check_level(1'b1, node_ready, "node_ready");
            report_test("reset", errors);
            load_tables();
            for (int g = 0; g < group_name.size(); g++) begin
                run_group(g);
            end
            $display("tests passed %0d failed %0d", tests_passed, tests_failed);
            if (tests_failed == 0 && errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

//--- tests/aggregate_trace.txt
# W table(0 neighbor info, 1 feature) addr data / T test name / N node / E node expected_sum
# numbers in hex except the table select, a neighbor word is pad, count, base node
W 1 10 0011
W 1 11 0102
W 1 12 1003
W 1 13 0004
W 1 14 0005
W 1 15 0006
W 1 16 0007
W 1 17 0008
W 1 18 0009
W 1 19 000a
W 1 1a 000b
W 1 1b 000c
W 1 20 fff0
W 1 21 8000
W 1 22 8020
W 0 01 0310
W 0 02 0000
W 0 03 0320
W 0 04 0810
W 0 05 0811
W 0 06 0812
W 0 07 0813
W 0 08 0814
W 0 09 0715
T single
N 01
E 01 1116
T zero_count
N 02
E 02 0000
T overflow
N 03
E 03 0010
T concurrent
N 04
N 05
N 06
N 07
N 08
N 09
E 04 1134
E 05 112c
E 06 1034
E 07 003c
E 08 0044
E 09 003f

//--- sim.f
+incdir+source
source/gcn_pkg.sv
source/rr_arbiter.sv
source/node_dispatcher.sv
source/edge_pe.sv
source/bus_arbiter.sv
source/graph_mem_cntl.sv
source/result_collector.sv
source/gcn_aggregate_top.sv
tests/gcn_aggregate_tb.sv
